// ==== cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// architectural state after reset, flags in n v z c order
`define CPU_RESET_PC    16'hC000
`define CPU_RESET_FLAGS 4'b0000

// immediate forms
`define CPU_OP_LDA_IMM 8'hA9
`define CPU_OP_LDX_IMM 8'hA2
`define CPU_OP_LDY_IMM 8'hA0
`define CPU_OP_ORA_IMM 8'h09
`define CPU_OP_AND_IMM 8'h29
`define CPU_OP_EOR_IMM 8'h49
`define CPU_OP_ADC_IMM 8'h69
`define CPU_OP_SBC_IMM 8'hE9

// absolute forms
`define CPU_OP_STA_ABS 8'h8D
`define CPU_OP_STX_ABS 8'h8E
`define CPU_OP_STY_ABS 8'h8C
`define CPU_OP_JMP_ABS 8'h4C

// single byte
`define CPU_OP_CLC 8'h18
`define CPU_OP_SEC 8'h38
`define CPU_OP_INX 8'hE8
`define CPU_OP_INY 8'hC8
`define CPU_OP_DEX 8'hCA
`define CPU_OP_DEY 8'h88
`define CPU_OP_NOP 8'hEA

`endif

// ==== cpu_pkg.sv ====
`include "cpu_macros.svh"

package cpu_pkg;

    // wishbone classic, master side
    typedef struct packed {
        logic [`CPU_ADDR_W-1:0] adr;
        logic [`CPU_DATA_W-1:0] dat;
        logic                   we;
        logic                   cyc;
        logic                   stb;
    } wb_req_t;

    typedef struct packed {
        logic [`CPU_DATA_W-1:0] dat;
        logic                   ack;
    } wb_rsp_t;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } flags_t;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        OPERAND_LO,
        OPERAND_HI,
        EXECUTE,
        WRITE
    } cpu_state_t;

    typedef enum logic [3:0] {
        ALU_HOLD,
        ALU_PASS,
        ALU_ADC,
        ALU_SBC,
        ALU_AND,
        ALU_ORA,
        ALU_EOR,
        ALU_INC,
        ALU_DEC
    } alu_op_t;

    typedef enum logic [1:0] {
        REG_NONE,
        REG_A,
        REG_X,
        REG_Y
    } reg_sel_t;

    // 6502 opcode layout aaabbbcc
    typedef struct packed {
        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;
    } opcode_fields_t;

    typedef union packed {
        logic [7:0]     raw;
        opcode_fields_t f;
    } opcode_u;

    typedef struct packed {
        alu_op_t    alu_op;
        reg_sel_t   src;
        reg_sel_t   dst;
        logic       nz_en;
        logic       v_en;
        logic       c_en;
        logic       c_fix;
        logic       c_val;
        // branch flag select: 0 n, 1 v, 2 c, 3 z
        logic [1:0] br_sel;
        logic       br_inv;
        logic       pc_inc;
        logic       pc_load_abs;
        logic       pc_branch;
        logic       opnd_cap;
        logic       bus_rd;
        logic       bus_wr;
        reg_sel_t   st_sel;
    } ctrl_t;

endpackage

// ==== cpu_alu.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu_alu (
    input  logic                   i_clock,
    input  logic                   i_rst,
    input  cpu_pkg::alu_op_t       i_op,
    input  logic [`CPU_DATA_W-1:0] i_src1,
    input  logic [`CPU_DATA_W-1:0] i_src2,
    input  logic                   i_c_in,
    output logic [`CPU_DATA_W-1:0] o_result,
    output cpu_pkg::flags_t        o_flags
);
    import cpu_pkg::*;

    logic [`CPU_DATA_W-1:0] addend;
    logic [`CPU_DATA_W:0]   sum;
    logic [`CPU_DATA_W-1:0] result_d;
    flags_t                 flags_d;

    // subtract is an add of the inverted operand
    assign addend = (i_op == ALU_SBC) ? ~i_src2 : i_src2;
    assign sum    = {1'b0, i_src1} + {1'b0, addend} + {{`CPU_DATA_W{1'b0}}, i_c_in};

    always_comb begin
        result_d = o_result;
        flags_d  = o_flags;
        case (i_op)
            ALU_PASS: result_d = i_src2;
            ALU_ADC, ALU_SBC: begin
                result_d  = sum[`CPU_DATA_W-1:0];
                flags_d.c = sum[`CPU_DATA_W];
                // overflow when both inputs agree in sign and the result does not
                flags_d.v = ~(i_src1[`CPU_DATA_W-1] ^ addend[`CPU_DATA_W-1]) &
                            (i_src1[`CPU_DATA_W-1] ^ sum[`CPU_DATA_W-1]);
            end
            ALU_AND:  result_d = i_src1 & i_src2;
            ALU_ORA:  result_d = i_src1 | i_src2;
            ALU_EOR:  result_d = i_src1 ^ i_src2;
            ALU_INC:  result_d = i_src1 + `CPU_DATA_W'(1);
            ALU_DEC:  result_d = i_src1 - `CPU_DATA_W'(1);
            default:  ;
        endcase
        flags_d.n = result_d[`CPU_DATA_W-1];
        flags_d.z = (result_d == '0);
    end

    // output stays put while the op is hold
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_result <= '0;
            o_flags  <= `CPU_RESET_FLAGS;
        end else if (i_op != ALU_HOLD) begin
            o_result <= result_d;
            o_flags  <= flags_d;
        end
    end

endmodule

// ==== cpu_bus_unit.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu_bus_unit (
    input  logic                   i_clock,
    input  logic                   i_rst,
    input  logic                   i_bus_go,
    input  logic                   i_bus_we,
    input  logic [`CPU_ADDR_W-1:0] i_addr,
    input  logic [`CPU_DATA_W-1:0] i_wdata,
    input  cpu_pkg::wb_rsp_t       i_wb,
    output cpu_pkg::wb_req_t       o_wb,
    output logic                   o_bus_done,
    output logic [`CPU_DATA_W-1:0] o_rdata
);
    import cpu_pkg::*;

    wb_req_t req_q;
    logic    ack_seen;

    // slave answers only while a strobe is out
    assign ack_seen = req_q.stb & i_wb.ack;

    ////////////////////
    // request register

    // address and data held from go until ack
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            req_q.we   <= 1'b0;
            req_q.cyc  <= 1'b0;
            req_q.stb  <= 1'b0;
            o_bus_done <= 1'b0;
        end else begin
            o_bus_done <= ack_seen;
            if (i_bus_go) begin
                req_q.adr <= i_addr;
                req_q.dat <= i_wdata;
                req_q.we  <= i_bus_we;
                req_q.cyc <= 1'b1;
                req_q.stb <= 1'b1;
            end else if (ack_seen) begin
                // cycle ends the clock after ack
                req_q.we  <= 1'b0;
                req_q.cyc <= 1'b0;
                req_q.stb <= 1'b0;
            end
        end
    end

    assign o_wb = req_q;

    ////////////////////
    // read buffer

    // valid together with o_bus_done
    always_ff @(posedge i_clock) begin
        if (ack_seen && !req_q.we) begin
            o_rdata <= i_wb.dat;
        end
    end

endmodule

// ==== cpu_sequencer.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu_sequencer (
    input  logic                   i_clock,
    input  logic                   i_rst,
    input  logic                   i_bus_done,
    input  logic [`CPU_DATA_W-1:0] i_rdata,
    input  logic                   i_branch_bit,
    output cpu_pkg::ctrl_t         o_ctrl,
    output logic                   o_bus_go,
    output logic                   o_bus_we,
    output logic                   o_addr_sel
);
    import cpu_pkg::*;

    cpu_state_t state;
    cpu_state_t state_d;
    opcode_u    opcode;
    logic       busy;
    alu_op_t    imm_op;
    logic       is_alu_imm;
    logic       is_branch;
    logic       is_store;
    logic       two_ops;
    logic       one_op;

    ////////////////////
    // decode

    // aaa picks the op in the immediate group, 100 and 110 are not kept
    always_comb begin
        case (opcode.f.aaa)
            3'b000:  imm_op = ALU_ORA;
            3'b001:  imm_op = ALU_AND;
            3'b010:  imm_op = ALU_EOR;
            3'b011:  imm_op = ALU_ADC;
            3'b101:  imm_op = ALU_PASS;
            3'b111:  imm_op = ALU_SBC;
            default: imm_op = ALU_HOLD;
        endcase
    end

    assign is_alu_imm = (opcode.f.cc == 2'b01) && (opcode.f.bbb == 3'b010) &&
                        (imm_op != ALU_HOLD);
    assign is_branch  = (opcode.f.cc == 2'b00) && (opcode.f.bbb == 3'b100);
    assign is_store   = (opcode.raw == `CPU_OP_STA_ABS) || (opcode.raw == `CPU_OP_STX_ABS) ||
                        (opcode.raw == `CPU_OP_STY_ABS);
    assign two_ops    = is_store || (opcode.raw == `CPU_OP_JMP_ABS);
    assign one_op     = is_alu_imm || is_branch || (opcode.raw == `CPU_OP_LDX_IMM) ||
                        (opcode.raw == `CPU_OP_LDY_IMM);

    ////////////////////
    // state machine

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state      <= FETCH;
            busy       <= 1'b0;
            opcode.raw <= `CPU_OP_NOP;
        end else begin
            state <= state_d;
            if (o_bus_go) begin
                busy <= 1'b1;
            end else if (i_bus_done) begin
                busy <= 1'b0;
            end
            if (state == FETCH && i_bus_done) begin
                opcode.raw <= i_rdata;
            end
        end
    end

    // wait states just hold the current state
    always_comb begin
        state_d = state;
        case (state)
            FETCH:      if (i_bus_done) state_d = DECODE;
            DECODE:     state_d = (one_op || two_ops) ? OPERAND_LO : EXECUTE;
            OPERAND_LO: if (i_bus_done) state_d = two_ops ? OPERAND_HI : EXECUTE;
            OPERAND_HI: if (i_bus_done) state_d = is_store ? WRITE : EXECUTE;
            EXECUTE:    state_d = FETCH;
            WRITE:      if (i_bus_done) state_d = FETCH;
            default:    state_d = FETCH;
        endcase
    end

    ////////////////////
    // control word

    always_comb begin
        o_ctrl        = '0;
        o_ctrl.br_sel = opcode.f.aaa[2:1];
        o_ctrl.br_inv = ~opcode.f.aaa[0];
        case (state)
            FETCH: begin
                o_ctrl.pc_inc = 1'b1;
                o_ctrl.bus_rd = ~busy;
            end
            OPERAND_LO, OPERAND_HI: begin
                o_ctrl.pc_inc   = 1'b1;
                o_ctrl.opnd_cap = 1'b1;
                o_ctrl.bus_rd   = ~busy;
            end
            EXECUTE: begin
                if (is_alu_imm) begin
                    o_ctrl.alu_op = imm_op;
                    o_ctrl.src    = REG_A;
                    o_ctrl.dst    = REG_A;
                    o_ctrl.nz_en  = 1'b1;
                    o_ctrl.v_en   = (imm_op == ALU_ADC) || (imm_op == ALU_SBC);
                    o_ctrl.c_en   = (imm_op == ALU_ADC) || (imm_op == ALU_SBC);
                end else if (is_branch) begin
                    // not taken means fall through to the next fetch
                    o_ctrl.pc_branch = i_branch_bit;
                end else begin
                    case (opcode.raw)
                        `CPU_OP_LDX_IMM: begin
                            o_ctrl.alu_op = ALU_PASS;
                            o_ctrl.dst    = REG_X;
                            o_ctrl.nz_en  = 1'b1;
                        end
                        `CPU_OP_LDY_IMM: begin
                            o_ctrl.alu_op = ALU_PASS;
                            o_ctrl.dst    = REG_Y;
                            o_ctrl.nz_en  = 1'b1;
                        end
                        `CPU_OP_INX, `CPU_OP_DEX: begin
                            o_ctrl.alu_op = (opcode.raw == `CPU_OP_INX) ? ALU_INC : ALU_DEC;
                            o_ctrl.src    = REG_X;
                            o_ctrl.dst    = REG_X;
                            o_ctrl.nz_en  = 1'b1;
                        end
                        `CPU_OP_INY, `CPU_OP_DEY: begin
                            o_ctrl.alu_op = (opcode.raw == `CPU_OP_INY) ? ALU_INC : ALU_DEC;
                            o_ctrl.src    = REG_Y;
                            o_ctrl.dst    = REG_Y;
                            o_ctrl.nz_en  = 1'b1;
                        end
                        `CPU_OP_CLC, `CPU_OP_SEC: begin
                            o_ctrl.c_en  = 1'b1;
                            o_ctrl.c_fix = 1'b1;
                            o_ctrl.c_val = (opcode.raw == `CPU_OP_SEC);
                        end
                        `CPU_OP_JMP_ABS: o_ctrl.pc_load_abs = 1'b1;
                        default: ;
                    endcase
                end
            end
            WRITE: begin
                o_ctrl.bus_wr = ~busy;
                case (opcode.raw)
                    `CPU_OP_STX_ABS: o_ctrl.st_sel = REG_X;
                    `CPU_OP_STY_ABS: o_ctrl.st_sel = REG_Y;
                    default:         o_ctrl.st_sel = REG_A;
                endcase
            end
            default: ;
        endcase
    end

    assign o_bus_go   = o_ctrl.bus_rd | o_ctrl.bus_wr;
    assign o_bus_we   = o_ctrl.bus_wr;
    assign o_addr_sel = (state == WRITE);

endmodule

// ==== cpu_datapath.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu_datapath (
    input  logic                   i_clock,
    input  logic                   i_rst,
    input  cpu_pkg::ctrl_t         i_ctrl,
    input  logic [`CPU_DATA_W-1:0] i_rdata,
    input  logic                   i_bus_done,
    input  logic                   i_addr_sel,
    output logic [`CPU_ADDR_W-1:0] o_addr,
    output logic [`CPU_DATA_W-1:0] o_wdata,
    output logic                   o_branch_bit
);
    import cpu_pkg::*;

    logic [`CPU_DATA_W-1:0] reg_a;
    logic [`CPU_DATA_W-1:0] reg_x;
    logic [`CPU_DATA_W-1:0] reg_y;
    flags_t                 flags;
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] opnd_addr;
    logic [`CPU_ADDR_W-1:0] branch_ofs;
    logic [`CPU_DATA_W-1:0] alu_src1;
    logic [`CPU_DATA_W-1:0] alu_result;
    flags_t                 alu_flags;
    ctrl_t                  wb_ctrl;

    function automatic logic [`CPU_DATA_W-1:0] sel_reg(input reg_sel_t sel);
        case (sel)
            REG_A:   sel_reg = reg_a;
            REG_X:   sel_reg = reg_x;
            REG_Y:   sel_reg = reg_y;
            default: sel_reg = '0;
        endcase
    endfunction

    always_comb begin
        alu_src1 = sel_reg(i_ctrl.src);
        o_wdata  = sel_reg(i_ctrl.st_sel);
    end

    // immediate or fetched byte is always the second operand
    cpu_alu alu_i (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_op     (i_ctrl.alu_op),
        .i_src1   (alu_src1),
        .i_src2   (i_rdata),
        .i_c_in   (flags.c),
        .o_result (alu_result),
        .o_flags  (alu_flags)
    );

    ////////////////////
    // register write-back

    // alu result is registered in execute, so commit one clock later
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            wb_ctrl <= '0;
            reg_a   <= '0;
            reg_x   <= '0;
            reg_y   <= '0;
            flags   <= `CPU_RESET_FLAGS;
        end else begin
            wb_ctrl <= i_ctrl;
            case (wb_ctrl.dst)
                REG_A:   reg_a <= alu_result;
                REG_X:   reg_x <= alu_result;
                REG_Y:   reg_y <= alu_result;
                default: ;
            endcase
            if (wb_ctrl.nz_en) begin
                flags.n <= alu_flags.n;
                flags.z <= alu_flags.z;
            end
            if (wb_ctrl.v_en) begin
                flags.v <= alu_flags.v;
            end
            if (wb_ctrl.c_en) begin
                flags.c <= wb_ctrl.c_fix ? wb_ctrl.c_val : alu_flags.c;
            end
        end
    end

    ////////////////////
    // program counter

    assign branch_ofs = {{(`CPU_ADDR_W - `CPU_DATA_W){i_rdata[`CPU_DATA_W-1]}}, i_rdata};

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            pc <= `CPU_RESET_PC;
        end else if (i_ctrl.pc_load_abs) begin
            pc <= opnd_addr;
        end else if (i_ctrl.pc_branch) begin
            pc <= pc + branch_ofs;
        end else if (i_ctrl.pc_inc && i_bus_done) begin
            pc <= pc + `CPU_ADDR_W'(1);
        end
    end

    // low byte arrives first, ends up in the bottom half after two reads
    always_ff @(posedge i_clock) begin
        if (i_ctrl.opnd_cap && i_bus_done) begin
            opnd_addr <= {i_rdata, opnd_addr[`CPU_ADDR_W-1:`CPU_DATA_W]};
        end
    end

    assign o_addr = i_addr_sel ? opnd_addr : pc;

    // flag compare, inverted when the branch expects a clear flag
    always_comb begin
        case (i_ctrl.br_sel)
            2'd0:    o_branch_bit = i_ctrl.br_inv ^ flags.n;
            2'd1:    o_branch_bit = i_ctrl.br_inv ^ flags.v;
            2'd2:    o_branch_bit = i_ctrl.br_inv ^ flags.c;
            default: o_branch_bit = i_ctrl.br_inv ^ flags.z;
        endcase
    end

endmodule

// ==== cpu_core.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu_core (
    input  logic             i_clock,
    input  logic             i_rst,
    output cpu_pkg::wb_req_t o_wb,
    input  cpu_pkg::wb_rsp_t i_wb
);
    import cpu_pkg::*;

    ctrl_t                  ctrl;
    logic                   bus_go;
    logic                   bus_we;
    logic                   bus_done;
    logic                   addr_sel;
    logic                   branch_bit;
    logic [`CPU_ADDR_W-1:0] addr;
    logic [`CPU_DATA_W-1:0] wdata;
    logic [`CPU_DATA_W-1:0] rdata;

    cpu_bus_unit bus_i (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_bus_go   (bus_go),
        .i_bus_we   (bus_we),
        .i_addr     (addr),
        .i_wdata    (wdata),
        .i_wb       (i_wb),
        .o_wb       (o_wb),
        .o_bus_done (bus_done),
        .o_rdata    (rdata)
    );

    cpu_sequencer seq_i (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_bus_done   (bus_done),
        .i_rdata      (rdata),
        .i_branch_bit (branch_bit),
        .o_ctrl       (ctrl),
        .o_bus_go     (bus_go),
        .o_bus_we     (bus_we),
        .o_addr_sel   (addr_sel)
    );

    cpu_datapath dp_i (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_ctrl       (ctrl),
        .i_rdata      (rdata),
        .i_bus_done   (bus_done),
        .i_addr_sel   (addr_sel),
        .o_addr       (addr),
        .o_wdata      (wdata),
        .o_branch_bit (branch_bit)
    );

endmodule

// ==== cpu_core_assertions.sv ====
`timescale 1ns/1ns

module cpu_core_assertions (
    input logic             i_clock,
    input logic             i_rst,
    input cpu_pkg::wb_req_t i_wb_req,
    input cpu_pkg::wb_rsp_t i_wb_rsp
);

    int violations = 0;

    // strobe only inside a cycle
    stb_in_cyc: assert property (@(posedge i_clock) disable iff (i_rst)
        i_wb_req.stb |-> i_wb_req.cyc)
    else begin
        $error("stb high without cyc");
        violations++;
    end

    // request held until the slave acks
    req_held: assert property (@(posedge i_clock) disable iff (i_rst)
        (i_wb_req.stb && !i_wb_rsp.ack) |=>
            (i_wb_req.stb && $stable(i_wb_req.adr) && $stable(i_wb_req.dat) &&
             $stable(i_wb_req.we)))
    else begin
        $error("request changed or dropped before ack");
        violations++;
    end

    idle_in_reset: assert property (@(posedge i_clock)
        (i_rst && $past(i_rst)) |-> !i_wb_req.stb)
    else begin
        $error("stb high during reset");
        violations++;
    end

endmodule

bind cpu_core cpu_core_assertions bus_checks_i (
    .i_clock  (i_clock),
    .i_rst    (i_rst),
    .i_wb_req (o_wb),
    .i_wb_rsp (i_wb)
);

// ==== cpu_core_tb.sv ====
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu_core_tb;
    import cpu_pkg::*;

    localparam int CLK_NS            = 40;
    localparam int N_FIXED           = 8;
    localparam int N_ENTRIES         = 16;
    // worst case per entry is 18 accesses of up to 7 cycles each
    localparam int ACCESS_PER_ENTRY  = 20;
    localparam int CYCLES_PER_ACCESS = 8;
    // two extra entries cover the index test and the final loop
    localparam int TIMEOUT_NS = (N_ENTRIES + 2) * ACCESS_PER_ENTRY * CYCLES_PER_ACCESS * CLK_NS
                                + 16 * CLK_NS;

    localparam alu_op_t    ALU_OPS [5]    = '{ALU_ADC, ALU_SBC, ALU_AND, ALU_ORA, ALU_EOR};
    localparam logic [7:0] BRANCH_OPS [8] = '{8'h10, 8'h30, 8'h50, 8'h70,
                                              8'h90, 8'hB0, 8'hD0, 8'hF0};

    typedef struct packed {
        alu_op_t    op;
        logic [7:0] a;
        logic [7:0] b;
        logic       cin;
        logic [7:0] br_op;
        logic [7:0] exp_store;
        logic       exp_taken;
    } entry_t;

    logic        clock  = 1'b0;
    logic        rst    = 1'b1;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp = '0;
    integer      seed   = 32'h1e5218fd;

    logic [7:0]  mem [0:65535];
    entry_t      entries [N_ENTRIES];
    wb_req_t     exp_wr_q [$];
    wb_req_t     exp_req;
    logic [15:0] load_addr;
    logic [15:0] jmp_addr;
    int          jmp_fetches = 0;
    logic        first_seen  = 1'b0;
    logic        active      = 1'b0;
    int          wait_left   = 0;

    cpu_core dut_i (
        .i_clock (clock),
        .i_rst   (rst),
        .o_wb    (wb_req),
        .i_wb    (wb_rsp)
    );

    always #(CLK_NS / 2) clock = ~clock;

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // adr only matters while a strobe is expected
    task automatic check_wb_req(input wb_req_t got, input wb_req_t exp, input string what);
        logic bad;
        bad = (got.we !== exp.we) || (got.cyc !== exp.cyc) || (got.stb !== exp.stb);
        if (exp.stb && (got.adr !== exp.adr)) begin
            bad = 1'b1;
        end
        if (bad) begin
            $display("[FAIL] %0t ns: %s got %h/%b/%b/%b, expected %h/%b/%b/%b (adr/we/cyc/stb)",
                     $time, what, got.adr, got.we, got.cyc, got.stb,
                     exp.adr, exp.we, exp.cyc, exp.stb);
            abort_run();
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    function automatic wb_req_t make_req(input logic [15:0] adr, input logic [7:0] dat,
                                         input logic we);
        wb_req_t r;
        r.adr = adr;
        r.dat = dat;
        r.we  = we;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        return r;
    endfunction

    function automatic logic [7:0] imm_opcode(input alu_op_t op);
        case (op)
            ALU_ADC: return `CPU_OP_ADC_IMM;
            ALU_SBC: return `CPU_OP_SBC_IMM;
            ALU_AND: return `CPU_OP_AND_IMM;
            ALU_ORA: return `CPU_OP_ORA_IMM;
            default: return `CPU_OP_EOR_IMM;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [7:0] opc, input flags_t f);
        case (opc)
            8'h10:   return !f.n;
            8'h30:   return f.n;
            8'h50:   return !f.v;
            8'h70:   return f.v;
            8'h90:   return !f.c;
            8'hB0:   return f.c;
            8'hD0:   return !f.z;
            default: return f.z;
        endcase
    endfunction

    // reference for the immediate ops
    // v is left alone by the logic ops
    task automatic model_alu(input alu_op_t op, input logic [7:0] a, input logic [7:0] b,
                             input logic cin, inout flags_t f, output logic [7:0] res);
        int usum;
        int ssum;
        f.c = cin;
        case (op)
            ALU_AND: res = a & b;
            ALU_ORA: res = a | b;
            ALU_EOR: res = a ^ b;
            ALU_SBC: begin
                // borrow is the inverted carry
                usum = int'(a) - int'(b) - (1 - int'(cin));
                ssum = int'($signed(a)) - int'($signed(b)) - (1 - int'(cin));
                res  = usum[7:0];
                f.c  = (usum >= 0);
                f.v  = (ssum > 127) || (ssum < -128);
            end
            default: begin
                usum = int'(a) + int'(b) + int'(cin);
                ssum = int'($signed(a)) + int'($signed(b)) + int'(cin);
                res  = usum[7:0];
                f.c  = (usum > 255);
                f.v  = (ssum > 127) || (ssum < -128);
            end
        endcase
        f.n = res[7];
        f.z = (res == 8'h00);
    endtask

    task automatic load_table();
        flags_t     f;
        logic [7:0] res;
        // op, a, b, carry in, branch, stored byte, branch taken
        entries[0] = '{ALU_ADC, 8'h50, 8'h50, 1'b0, 8'h70, 8'hA0, 1'b1};
        entries[1] = '{ALU_ADC, 8'hFF, 8'h01, 1'b0, 8'hF0, 8'h00, 1'b1};
        entries[2] = '{ALU_SBC, 8'h10, 8'h20, 1'b1, 8'h90, 8'hF0, 1'b1};
        entries[3] = '{ALU_SBC, 8'h80, 8'h01, 1'b1, 8'h50, 8'h7F, 1'b0};
        entries[4] = '{ALU_AND, 8'hF0, 8'h3C, 1'b0, 8'h30, 8'h30, 1'b0};
        entries[5] = '{ALU_ORA, 8'h80, 8'h01, 1'b1, 8'hB0, 8'h81, 1'b1};
        entries[6] = '{ALU_EOR, 8'h5A, 8'h5A, 1'b0, 8'hD0, 8'h00, 1'b0};
        entries[7] = '{ALU_ADC, 8'h7F, 8'h00, 1'b1, 8'h10, 8'h80, 1'b0};
        f = `CPU_RESET_FLAGS;
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (i >= N_FIXED) begin
                entries[i].op    = ALU_OPS[{$random(seed)} % 5];
                entries[i].a     = 8'($random(seed));
                entries[i].b     = 8'($random(seed));
                entries[i].cin   = 1'($random(seed));
                entries[i].br_op = BRANCH_OPS[{$random(seed)} % 8];
            end
            // flags carry over so v is tracked through every entry
            model_alu(entries[i].op, entries[i].a, entries[i].b, entries[i].cin, f, res);
            if (i >= N_FIXED) begin
                entries[i].exp_store = res;
                entries[i].exp_taken = branch_taken(entries[i].br_op, f);
            end
        end
    endtask

    task automatic put_byte(input logic [7:0] value);
        mem[load_addr] = value;
        load_addr      = load_addr + 16'd1;
    endtask

    task automatic imm_instr(input logic [7:0] opc, input logic [7:0] value);
        put_byte(opc);
        put_byte(value);
    endtask

    task automatic abs_instr(input logic [7:0] opc, input logic [15:0] addr);
        put_byte(opc);
        put_byte(addr[7:0]);
        put_byte(addr[15:8]);
    endtask

    task automatic build_program();
        load_addr = `CPU_RESET_PC;
        for (int i = 0; i < N_ENTRIES; i++) begin
            imm_instr(`CPU_OP_LDX_IMM, 8'h00);
            imm_instr(`CPU_OP_LDA_IMM, entries[i].a);
            put_byte(entries[i].cin ? `CPU_OP_SEC : `CPU_OP_CLC);
            imm_instr(imm_opcode(entries[i].op), entries[i].b);
            abs_instr(`CPU_OP_STA_ABS, 16'h0200 + 16'(i));
            // taken branch hops over the inx
            imm_instr(entries[i].br_op, 8'h01);
            put_byte(`CPU_OP_INX);
            abs_instr(`CPU_OP_STX_ABS, 16'h0300 + 16'(i));
            exp_wr_q.push_back(make_req(16'h0200 + 16'(i), entries[i].exp_store, 1'b1));
            exp_wr_q.push_back(make_req(16'h0300 + 16'(i),
                                        entries[i].exp_taken ? 8'h00 : 8'h01, 1'b1));
        end
        // index wraparound both ways
        imm_instr(`CPU_OP_LDY_IMM, 8'hFF);
        put_byte(`CPU_OP_INY);
        abs_instr(`CPU_OP_STY_ABS, 16'h0400);
        imm_instr(`CPU_OP_LDX_IMM, 8'h00);
        put_byte(`CPU_OP_DEX);
        abs_instr(`CPU_OP_STX_ABS, 16'h0401);
        exp_wr_q.push_back(make_req(16'h0400, 8'h00, 1'b1));
        exp_wr_q.push_back(make_req(16'h0401, 8'hFF, 1'b1));
        jmp_addr = load_addr;
        abs_instr(`CPU_OP_JMP_ABS, jmp_addr);
    endtask

    ////////////////////
    // memory model

    // one ack per access after 0 to 3 wait cycles
    always @(posedge clock) begin
        if (rst) begin
            wb_rsp <= '0;
            active = 1'b0;
        end else if (wb_rsp.ack) begin
            wb_rsp.ack <= 1'b0;
            active = 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!active) begin
                active    = 1'b1;
                wait_left = {$random(seed)} % 4;
            end
            if (wait_left == 0) begin
                wb_rsp.ack <= 1'b1;
                wb_rsp.dat <= mem[wb_req.adr];
                if (wb_req.we) begin
                    mem[wb_req.adr] = wb_req.dat;
                end
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    ////////////////////
    // bus monitor

    always @(negedge clock) begin
        if (rst) begin
            check_wb_req(wb_req, '0, "bus during reset");
        end else begin
            if (wb_req.stb && !first_seen) begin
                check_wb_req(wb_req, make_req(`CPU_RESET_PC, 8'h00, 1'b0), "first request");
                first_seen = 1'b1;
            end
            if (wb_req.stb && wb_rsp.ack) begin
                if (wb_req.we && exp_wr_q.size() == 0) begin
                    $display("An extra write to address %h happened after the last store",
                             wb_req.adr);
                    abort_run();
                end else if (wb_req.we) begin
                    exp_req = exp_wr_q.pop_front();
                    check_wb_req(wb_req, exp_req, "write request");
                    check_byte(wb_req.dat, exp_req.dat,
                               $sformatf("byte stored at %h", wb_req.adr));
                end else if (exp_wr_q.size() == 0) begin
                    // only the jmp and its two operand bytes may be read now
                    if (wb_req.adr < jmp_addr || wb_req.adr > jmp_addr + 16'd2) begin
                        $display("[FAIL] %0t ns: read at %h outside the final jmp at %h",
                                 $time, wb_req.adr, jmp_addr);
                        abort_run();
                    end else if (wb_req.adr == jmp_addr) begin
                        jmp_fetches = jmp_fetches + 1;
                    end
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("The run timed out after %0d ns before the final loop was reached",
                 TIMEOUT_NS);
        abort_run();
    end

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[7:0] ^ i[15:8];
        end
        load_table();
        build_program();
        repeat (16) @(posedge clock);
        rst <= 1'b0;
        wait (jmp_fetches >= 3);
        @(negedge clock);
        if (dut_i.bus_checks_i.violations == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("A bus protocol assertion failed during the run");
            abort_run();
        end
    end

endmodule

// ==== cpu_core.f ====
+incdir+.
cpu_pkg.sv
cpu_alu.sv
cpu_bus_unit.sv
cpu_sequencer.sv
cpu_datapath.sv
cpu_core.sv
cpu_core_assertions.sv
cpu_core_tb.sv
